/* camera/pixel_reconstruct.sv */
`timescale 1ns/100ps
`include "tracker_settings.svh"

module pixel_reconstruct
   import tracker_pkg::*;
(
   input  logic       clk_camera,
   input  logic       sys_rst_camera,
   input  logic [7:0] cam_data_i,
   input  logic       cam_pclk_i,
   input  logic       cam_hsync_i,
   input  logic       cam_vsync_i,
   output logic       pixel_valid_o,
   output pixel565_u  pixel_data_o,
   output hcount_t    pixel_hcount_o,
   output vcount_t    pixel_vcount_o
);

   // two-flop synchronisers on the whole camera bus
   logic [7:0] data_s1;
   logic [7:0] data_s2;
   logic       pclk_s1;
   logic       pclk_s2;
   logic       hs_s1;
   logic       hs_s2;
   logic       vs_s1;
   logic       vs_s2;

   always_ff @(posedge clk_camera) begin
      data_s1 <= cam_data_i;
      data_s2 <= data_s1;
      pclk_s1 <= cam_pclk_i;
      pclk_s2 <= pclk_s1;
      hs_s1   <= cam_hsync_i;
      hs_s2   <= hs_s1;
      vs_s1   <= cam_vsync_i;
      vs_s2   <= vs_s1;
   end

   // edge detect stage, data and syncs kept aligned with rise_q
   logic       pclk_q;
   logic       rise_q;
   logic       hs_q;
   logic       vs_q;
   logic [7:0] data_q;

   always_ff @(posedge clk_camera) begin
      data_q <= data_s2;
      if (sys_rst_camera) begin
         pclk_q <= 1'b0;
         rise_q <= 1'b0;
         hs_q   <= 1'b0;
         vs_q   <= 1'b0;
      end else begin
         pclk_q <= pclk_s2;
         rise_q <= pclk_s2 & ~pclk_q;
         hs_q   <= hs_s2;
         vs_q   <= vs_s2;
      end
   end

   // byte pairing and position counters
   logic       hs_d;
   logic       vs_d;
   logic       hs_fall;
   logic       vs_fall;
   logic       take_byte;
   logic       hi_done;
   logic [7:0] hi_byte;
   hcount_t    hcount;
   vcount_t    vcount;

   assign hs_fall   = hs_d & ~hs_q;
   assign vs_fall   = vs_d & ~vs_q;
   // bytes only count while both syncs are high
   assign take_byte = rise_q & hs_q & vs_q;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pixel_valid_o <= 1'b0;
         hi_done       <= 1'b0;
         hcount        <= '0;
         vcount        <= '0;
         hs_d          <= 1'b0;
         vs_d          <= 1'b0;
      end else begin
         hs_d          <= hs_q;
         vs_d          <= vs_q;
         pixel_valid_o <= 1'b0;
         if (take_byte) begin
            hi_done <= ~hi_done;
            if (hi_done) begin
               // low byte completes the pixel
               pixel_valid_o <= 1'b1;
               hcount        <= hcount + 1'b1;
            end
         end else if (!hs_q || !vs_q) begin
            // blanking, next byte is a high byte again
            hi_done <= 1'b0;
         end
         if (hs_fall) begin
            hcount <= '0;
         end
         // frame start wins over a line end in the same cycle
         if (vs_fall) begin
            vcount <= '0;
         end else if (hs_fall && vs_q) begin
            vcount <= vcount + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (take_byte) begin
         if (!hi_done) begin
            hi_byte <= data_q;
         end else begin
            pixel_data_o.bytes.hi <= hi_byte;
            pixel_data_o.bytes.lo <= data_q;
            pixel_hcount_o        <= hcount;
            pixel_vcount_o        <= vcount;
         end
      end
   end

   // a line longer than the frame means the bus timing is off
   a_hcount_in_frame : assert property (
      @(posedge clk_camera) disable iff (sys_rst_camera)
      pixel_valid_o |-> (pixel_hcount_o < `FRAME_W)
   );

endmodule

/* common/tracker_pkg.sv */
`include "tracker_settings.svh"

package tracker_pkg;

   // one 16-bit camera word, seen as bytes on the wire or as rgb565 fields
   typedef union packed {
      // as received, high byte first
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;
      } bytes;
      // colour fields
      struct packed {
         logic [4:0] r;
         logic [5:0] g;
         logic [4:0] b;
      } rgb;
   } pixel565_u;

   // column and row positions
   typedef logic [`HCOUNT_W-1:0] hcount_t;
   typedef logic [`VCOUNT_W-1:0] vcount_t;

   // coordinate sums, pixel counts and quotients
   typedef logic [`DIV_W-1:0] sum_t;

endpackage

/* common/tracker_settings.svh */
`ifndef TRACKER_SETTINGS_SVH
`define TRACKER_SETTINGS_SVH

// camera frame size in pixels
`define FRAME_W 320
`define FRAME_H 180

// counter widths, wide enough for the frame above
`define HCOUNT_W 9
`define VCOUNT_W 8

// inclusive cr window for the pink marker
`define CR_LOWER 160
`define CR_UPPER 240

// dividend width, bounds the per-frame coordinate sums
`define DIV_W 24

`endif

/* src/blob_tracker_top.sv */
`timescale 1ns/100ps

module blob_tracker_top
   import tracker_pkg::*;
(
   input  logic        clk_camera,
   input  logic        sys_rst_camera,
   input  logic [7:0]  cam_data_i,
   input  logic        cam_pclk_i,
   input  logic        cam_hsync_i,
   input  logic        cam_vsync_i,
   input  logic        mode_i,
   output logic        px_valid_o,
   output logic [15:0] px_data_o,
   output hcount_t     px_hcount_o,
   output vcount_t     px_vcount_o,
   output logic        com_valid_o,
   output hcount_t     com_x_o,
   output vcount_t     com_y_o
);

   // reconstructed pixels
   logic      pixel_valid;
   pixel565_u pixel_data;
   hcount_t   pixel_hcount;
   vcount_t   pixel_vcount;

   // masked pixels, shared by the tracker and the overlay
   logic      mask_valid;
   logic      mask;
   pixel565_u mask_pixel;
   hcount_t   mask_hcount;
   vcount_t   mask_vcount;

   pixel_reconstruct pixel_reconstruct_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pixel_valid_o  (pixel_valid),
      .pixel_data_o   (pixel_data),
      .pixel_hcount_o (pixel_hcount),
      .pixel_vcount_o (pixel_vcount)
   );

   chroma_mask chroma_mask_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pixel_valid_i  (pixel_valid),
      .pixel_data_i   (pixel_data),
      .pixel_hcount_i (pixel_hcount),
      .pixel_vcount_i (pixel_vcount),
      .mask_valid_o   (mask_valid),
      .mask_o         (mask),
      .mask_pixel_o   (mask_pixel),
      .mask_hcount_o  (mask_hcount),
      .mask_vcount_o  (mask_vcount)
   );

   center_of_mass center_of_mass_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_valid_i   (mask_valid),
      .mask_i         (mask),
      .mask_hcount_i  (mask_hcount),
      .mask_vcount_i  (mask_vcount),
      .com_valid_o    (com_valid_o),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o)
   );

   // overlay follows the center straight from the tracker outputs
   crosshair_overlay crosshair_overlay_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mode_i         (mode_i),
      .mask_valid_i   (mask_valid),
      .mask_i         (mask),
      .mask_pixel_i   (mask_pixel),
      .mask_hcount_i  (mask_hcount),
      .mask_vcount_i  (mask_vcount),
      .com_valid_i    (com_valid_o),
      .com_x_i        (com_x_o),
      .com_y_i        (com_y_o),
      .px_valid_o     (px_valid_o),
      .px_data_o      (px_data_o),
      .px_hcount_o    (px_hcount_o),
      .px_vcount_o    (px_vcount_o)
   );

endmodule

/* src/chroma_mask.sv */
`timescale 1ns/100ps
`include "tracker_settings.svh"

module chroma_mask
   import tracker_pkg::*;
(
   input  logic      clk_camera,
   input  logic      sys_rst_camera,
   input  logic      pixel_valid_i,
   input  pixel565_u pixel_data_i,
   input  hcount_t   pixel_hcount_i,
   input  vcount_t   pixel_vcount_i,
   output logic      mask_valid_o,
   output logic      mask_o,
   output pixel565_u mask_pixel_o,
   output hcount_t   mask_hcount_o,
   output vcount_t   mask_vcount_o
);

   // fields widened to 8 bits, low bits zero
   logic [7:0]  red8;
   logic [7:0]  green8;
   logic [7:0]  blue8;

   // stage 1 products
   logic        valid_q;
   logic [16:0] prod_r;
   logic [16:0] prod_g;
   logic [16:0] prod_b;
   pixel565_u   pixel_q;
   hcount_t     hcount_q;
   vcount_t     vcount_q;

   // stage 2 sum, never negative with 8-bit inputs
   logic [16:0] cr_sum;
   logic [8:0]  cr;

   assign red8   = {pixel_data_i.rgb.r, 3'b000};
   assign green8 = {pixel_data_i.rgb.g, 2'b00};
   assign blue8  = {pixel_data_i.rgb.b, 3'b000};

   assign cr_sum = 17'd32768 + prod_r - prod_g - prod_b;
   // floor divide by 256
   assign cr     = cr_sum[16:8];

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         valid_q      <= 1'b0;
         mask_valid_o <= 1'b0;
      end else begin
         valid_q      <= pixel_valid_i;
         mask_valid_o <= valid_q;
      end
   end

   always_ff @(posedge clk_camera) begin
      // cr weights 112, 94, 18 out of 256
      prod_r        <= 17'(red8) * 17'd112;
      prod_g        <= 17'(green8) * 17'd94;
      prod_b        <= 17'(blue8) * 17'd18;
      pixel_q       <= pixel_data_i;
      hcount_q      <= pixel_hcount_i;
      vcount_q      <= pixel_vcount_i;
      // inclusive window on both ends
      mask_o        <= (cr >= 9'(`CR_LOWER)) && (cr <= 9'(`CR_UPPER));
      mask_pixel_o  <= pixel_q;
      mask_hcount_o <= hcount_q;
      mask_vcount_o <= vcount_q;
   end

endmodule

/* src/crosshair_overlay.sv */
`timescale 1ns/100ps

module crosshair_overlay
   import tracker_pkg::*;
(
   input  logic        clk_camera,
   input  logic        sys_rst_camera,
   input  logic        mode_i,
   input  logic        mask_valid_i,
   input  logic        mask_i,
   input  pixel565_u   mask_pixel_i,
   input  hcount_t     mask_hcount_i,
   input  vcount_t     mask_vcount_i,
   input  logic        com_valid_i,
   input  hcount_t     com_x_i,
   input  vcount_t     com_y_i,
   output logic        px_valid_o,
   output logic [15:0] px_data_o,
   output hcount_t     px_hcount_o,
   output vcount_t     px_vcount_o
);

   // latest center, (0,0) until the first result
   hcount_t     held_x;
   vcount_t     held_y;
   logic [15:0] base_px;
   logic        on_cross;

   // mode 0 camera colours, mode 1 mask as black or white
   assign base_px  = mode_i ? {16{mask_i}}
                            : {mask_pixel_i.rgb.r, mask_pixel_i.rgb.g, mask_pixel_i.rgb.b};
   assign on_cross = (mask_hcount_i == held_x) || (mask_vcount_i == held_y);

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         held_x     <= '0;
         held_y     <= '0;
         px_valid_o <= 1'b0;
      end else begin
         px_valid_o <= mask_valid_i;
         if (com_valid_i) begin
            held_x <= com_x_i;
            held_y <= com_y_i;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      // white crosshair over either mode
      px_data_o   <= on_cross ? 16'hffff : base_px;
      px_hcount_o <= mask_hcount_i;
      px_vcount_o <= mask_vcount_i;
   end

endmodule

/* tb.f */
+incdir+common
common/tracker_pkg.sv
camera/pixel_reconstruct.sv
src/chroma_mask.sv
tracking/com_divider.sv
tracking/center_of_mass.sv
src/crosshair_overlay.sv
src/blob_tracker_top.sv
tests/blob_checker.sv
tests/tb_blob_tracker.sv

/* tests/blob_checker.sv */
`timescale 1ns/100ps

module blob_checker
   import tracker_pkg::*;
(
   input  logic        clk_camera,
   input  logic        px_valid_i,
   input  logic [15:0] px_data_i,
   input  hcount_t     px_hcount_i,
   input  vcount_t     px_vcount_i,
   input  logic        com_valid_i,
   input  hcount_t     com_x_i,
   input  vcount_t     com_y_i,
   output logic        timeout_o
);

   // three frames of about 464k cycles each, plus margin
   localparam longint TIMEOUT_CYCLES = 2_000_000;
   localparam int     NUM_TESTS      = 5;

   // expected display pixels, in send order
   logic [15:0] data_q [$];
   hcount_t     hcount_q [$];
   vcount_t     vcount_q [$];
   int          pixel_test_q [$];

   // expected centers, one per frame with masked pixels
   hcount_t     cx_q [$];
   vcount_t     cy_q [$];
   int          center_test_q [$];

   int          checks [NUM_TESTS];
   int          errors [NUM_TESTS];
   int          cur_test = 0;
   longint      cycles = 0;

   function automatic string test_name(int idx);
      case (idx)
         0:       return "reset_state";
         1:       return "camera_mode";
         2:       return "center_of_mass";
         3:       return "mask_mode";
         default: return "empty_frame";
      endcase
   endfunction

   task automatic set_test(input int idx);
      cur_test = idx;
   endtask

   task automatic expect_pixel(input logic [15:0] data, input hcount_t h, input vcount_t v,
                               input int idx);
      data_q.push_back(data);
      hcount_q.push_back(h);
      vcount_q.push_back(v);
      pixel_test_q.push_back(idx);
   endtask

   task automatic expect_center(input hcount_t x, input vcount_t y, input int idx);
      cx_q.push_back(x);
      cy_q.push_back(y);
      center_test_q.push_back(idx);
   endtask

   function automatic int pending_pixels();
      return data_q.size();
   endfunction

   function automatic int pending_centers();
      return cx_q.size();
   endfunction

   task automatic finish_test(input int idx);
      $display("test %s finished: %0d checks, %0d errors", test_name(idx), checks[idx],
               errors[idx]);
   endtask

   // both strobes quiet through reset and the idle window after it
   task automatic check_idle();
      checks[0]++;
      if (px_valid_i !== 1'b0) begin
         errors[0]++;
         $display("** Error %s: px_valid expected 0 actual %b", test_name(0), px_valid_i);
      end
      if (com_valid_i !== 1'b0) begin
         errors[0]++;
         $display("** Error %s: com_valid expected 0 actual %b", test_name(0), com_valid_i);
      end
   endtask

   task automatic compare_pixel();
      logic [15:0] exp_data;
      hcount_t     exp_h;
      vcount_t     exp_v;
      int          idx;
      if (data_q.size() == 0) begin
         errors[cur_test]++;
         $display("error in %s: a display pixel at (%0d,%0d) came out with none sent",
                  test_name(cur_test), px_hcount_i, px_vcount_i);
      end else begin
         exp_data = data_q.pop_front();
         exp_h    = hcount_q.pop_front();
         exp_v    = vcount_q.pop_front();
         idx      = pixel_test_q.pop_front();
         checks[idx]++;
         if (px_data_i !== exp_data) begin
            errors[idx]++;
            $display("** Error %s: pixel (%0d,%0d) expected %h actual %h", test_name(idx),
                     exp_h, exp_v, exp_data, px_data_i);
         end
         // position travels with the pixel
         if (px_hcount_i !== exp_h || px_vcount_i !== exp_v) begin
            errors[idx]++;
            $display("** Error %s: position expected (%0d,%0d) actual (%0d,%0d)",
                     test_name(idx), exp_h, exp_v, px_hcount_i, px_vcount_i);
         end
      end
   endtask

   task automatic compare_center();
      hcount_t exp_x;
      vcount_t exp_y;
      int      idx;
      if (cx_q.size() == 0) begin
         errors[cur_test]++;
         $display("error in %s: a center result (%0d,%0d) came with no frame expecting one",
                  test_name(cur_test), com_x_i, com_y_i);
      end else begin
         exp_x = cx_q.pop_front();
         exp_y = cy_q.pop_front();
         idx   = center_test_q.pop_front();
         checks[idx]++;
         if (com_x_i !== exp_x || com_y_i !== exp_y) begin
            errors[idx]++;
            $display("** Error %s: center expected (%0d,%0d) actual (%0d,%0d)",
                     test_name(idx), exp_x, exp_y, com_x_i, com_y_i);
         end
      end
   endtask

   // leftovers count as errors, then one totals line
   function automatic int report_totals();
      int total_checks;
      int total_errors;
      total_checks = 0;
      total_errors = 0;
      if (data_q.size() != 0) begin
         errors[cur_test]++;
         $display("error: %0d expected display pixels never came out", data_q.size());
      end
      if (cx_q.size() != 0) begin
         errors[cur_test]++;
         $display("error: %0d expected center results never came out", cx_q.size());
      end
      for (int i = 0; i < NUM_TESTS; i++) begin
         total_checks += checks[i];
         total_errors += errors[i];
      end
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_errors);
      return total_errors;
   endfunction

   initial begin
      timeout_o = 1'b0;
   end

   // outputs sampled at the edge, before the dut updates them
   always @(posedge clk_camera) begin
      cycles++;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("timeout: the run was still going after %0d clock cycles", cycles);
         timeout_o <= 1'b1;
      end
      // first edge only loads the reset values
      if (cur_test == 0 && cycles > 1) begin
         check_idle();
      end
      if (px_valid_i === 1'b1) begin
         compare_pixel();
      end
      if (com_valid_i === 1'b1) begin
         compare_center();
      end
   end

endmodule

/* tests/tb_blob_tracker.sv */
`timescale 1ns/100ps
`include "tracker_settings.svh"

module tb_blob_tracker
   import tracker_pkg::*;
();

   // pink marker colour, r 31 g 10 b 20, cr near 210
   localparam logic [15:0] PINK   = 16'hf954;
   // marker rectangle placed in frame 1
   localparam int          BOX_X0 = 200;
   localparam int          BOX_X1 = 239;
   localparam int          BOX_Y0 = 60;
   localparam int          BOX_Y1 = 99;

   logic        clk_camera;
   logic        sys_rst_camera;
   logic [7:0]  cam_data;
   logic        cam_pclk;
   logic        cam_hsync;
   logic        cam_vsync;
   logic        mode;
   logic        px_valid;
   logic [15:0] px_data;
   hcount_t     px_hcount;
   vcount_t     px_vcount;
   logic        com_valid;
   hcount_t     com_x;
   vcount_t     com_y;
   logic        timed_out;

   // reference model state
   // held center as the overlay should see it
   hcount_t     exp_cx;
   vcount_t     exp_cy;
   // masked coordinate sums of the frame being sent
   longint      sum_x;
   longint      sum_y;
   longint      hits;
   int          fail_count;

   initial begin
      clk_camera = 1'b0;
      forever #2 clk_camera = ~clk_camera;
   end

   // cr from the 8-bit expanded fields, floor of the weighted sum over 256
   function automatic int cr_of(logic [15:0] px);
      int r8;
      int g8;
      int b8;
      r8 = int'(px[15:11]) * 8;
      g8 = int'(px[10:5]) * 4;
      b8 = int'(px[4:0]) * 8;
      return (32768 + 112 * r8 - 94 * g8 - 18 * b8) / 256;
   endfunction

   function automatic bit masked(logic [15:0] px);
      int cr;
      cr = cr_of(px);
      return (cr >= `CR_LOWER) && (cr <= `CR_UPPER);
   endfunction

   // crosshair first, then camera colour or black/white mask
   function automatic logic [15:0] display_of(logic [15:0] px, logic md, hcount_t cx,
                                              vcount_t cy, int col, int row);
      if (col == int'(cx) || row == int'(cy)) begin
         return 16'hffff;
      end else if (md) begin
         return {16{masked(px)}};
      end
      return px;
   endfunction

   // kind 0 random with pink box, 1 random, 2 random without red
   function automatic logic [15:0] pick_pixel(int kind, int col, int row);
      logic [15:0] rnd;
      rnd = 16'($urandom);
      if (kind == 0 && col >= BOX_X0 && col <= BOX_X1 && row >= BOX_Y0 && row <= BOX_Y1) begin
         return PINK;
      end else if (kind == 2) begin
         // zero red keeps cr at or under 128
         return rnd & 16'h07ff;
      end
      return rnd;
   endfunction

   // one pclk period, byte set up during the low half
   task automatic pclk_period(input logic [7:0] data);
      cam_data <= data;
      cam_pclk <= 1'b0;
      repeat (2) @(posedge clk_camera);
      cam_pclk <= 1'b1;
      repeat (2) @(posedge clk_camera);
   endtask

   task automatic send_pixel(input logic [15:0] px, input int col, input int row,
                             input logic md, input int test_idx);
      blob_checker_inst.expect_pixel(display_of(px, md, exp_cx, exp_cy, col, row),
                                     hcount_t'(col), vcount_t'(row), test_idx);
      if (masked(px)) begin
         sum_x += col;
         sum_y += row;
         hits++;
      end
      // high byte goes first
      pclk_period(px[15:8]);
      pclk_period(px[7:0]);
   endtask

   // floor averages, an empty frame yields no result
   task automatic close_frame(input int test_idx);
      if (hits != 0) begin
         exp_cx = hcount_t'(sum_x / hits);
         exp_cy = vcount_t'(sum_y / hits);
         blob_checker_inst.expect_center(exp_cx, exp_cy, test_idx);
      end
   endtask

   task automatic send_frame(input int kind, input logic md, input int pixel_test,
                             input int center_test);
      logic [15:0] px;
      mode      <= md;
      cam_vsync <= 1'b1;
      sum_x = 0;
      sum_y = 0;
      hits  = 0;
      repeat (4) pclk_period(8'h00);
      for (int row = 0; row < `FRAME_H; row++) begin
         cam_hsync <= 1'b1;
         for (int col = 0; col < `FRAME_W; col++) begin
            px = pick_pixel(kind, col, row);
            send_pixel(px, col, row, md, pixel_test);
         end
         // expected center queued before the dividers can finish
         if (row == `FRAME_H - 1) begin
            close_frame(center_test);
         end
         // hsync low gap between lines
         cam_hsync <= 1'b0;
         repeat (4) pclk_period(8'h00);
      end
      // vsync low gap between frames
      cam_vsync <= 1'b0;
      repeat (4) pclk_period(8'h00);
   endtask

   task automatic wait_drained();
      while (blob_checker_inst.pending_pixels() != 0
             || blob_checker_inst.pending_centers() != 0) begin
         @(posedge clk_camera);
      end
   endtask

   initial begin
      void'($urandom(9));
      sys_rst_camera = 1'b1;
      cam_data       = 8'h00;
      cam_pclk       = 1'b0;
      cam_hsync      = 1'b0;
      cam_vsync      = 1'b0;
      mode           = 1'b0;
      exp_cx         = '0;
      exp_cy         = '0;
      repeat (16) @(posedge clk_camera);
      sys_rst_camera <= 1'b0;
      // idle window after release still counts as reset state
      repeat (16) @(posedge clk_camera);
      blob_checker_inst.finish_test(0);

      blob_checker_inst.set_test(1);
      send_frame(0, 1'b0, 1, 2);
      wait_drained();
      blob_checker_inst.finish_test(1);
      blob_checker_inst.finish_test(2);

      blob_checker_inst.set_test(3);
      send_frame(1, 1'b1, 3, 3);
      wait_drained();
      blob_checker_inst.finish_test(3);

      blob_checker_inst.set_test(4);
      send_frame(2, 1'b0, 4, 4);
      // full divider window, any result here is unexpected
      repeat (2 * `DIV_W + 16) @(posedge clk_camera);
      wait_drained();
      blob_checker_inst.finish_test(4);

      fail_count = blob_checker_inst.report_totals();
      if (fail_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      wait (timed_out === 1'b1);
      $display("SIMULATION FAILED");
      $finish;
   end

   blob_tracker_top blob_tracker_top_inst (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data),
      .cam_pclk_i     (cam_pclk),
      .cam_hsync_i    (cam_hsync),
      .cam_vsync_i    (cam_vsync),
      .mode_i         (mode),
      .px_valid_o     (px_valid),
      .px_data_o      (px_data),
      .px_hcount_o    (px_hcount),
      .px_vcount_o    (px_vcount),
      .com_valid_o    (com_valid),
      .com_x_o        (com_x),
      .com_y_o        (com_y)
   );

   blob_checker blob_checker_inst (
      .clk_camera  (clk_camera),
      .px_valid_i  (px_valid),
      .px_data_i   (px_data),
      .px_hcount_i (px_hcount),
      .px_vcount_i (px_vcount),
      .com_valid_i (com_valid),
      .com_x_i     (com_x),
      .com_y_i     (com_y),
      .timeout_o   (timed_out)
   );

endmodule

/* tracking/center_of_mass.sv */
`timescale 1ns/100ps
`include "tracker_settings.svh"

module center_of_mass
   import tracker_pkg::*;
(
   input  logic    clk_camera,
   input  logic    sys_rst_camera,
   input  logic    mask_valid_i,
   input  logic    mask_i,
   input  hcount_t mask_hcount_i,
   input  vcount_t mask_vcount_i,
   output logic    com_valid_o,
   output hcount_t com_x_o,
   output vcount_t com_y_o
);

   // running sums for the frame in progress
   sum_t sum_x;
   sum_t sum_y;
   sum_t pix_count;

   // sums including the current pixel
   sum_t next_x;
   sum_t next_y;
   sum_t next_count;

   // copies handed to the dividers
   sum_t x_dividend;
   sum_t y_dividend;
   sum_t divisor;

   logic hit;
   logic frame_end;
   logic div_start;

   logic x_done;
   logic y_done;
   sum_t x_quot;
   sum_t y_quot;
   // join of the two peers, same start and same run length
   logic both_done;

   assign hit       = mask_valid_i & mask_i;
   // last pixel of the frame triggers tabulation
   assign frame_end = mask_valid_i
                      && (mask_hcount_i == hcount_t'(`FRAME_W - 1))
                      && (mask_vcount_i == vcount_t'(`FRAME_H - 1));
   assign both_done = x_done & y_done;

   always_comb begin
      next_x     = sum_x;
      next_y     = sum_y;
      next_count = pix_count;
      if (hit) begin
         next_x     = sum_x + sum_t'(mask_hcount_i);
         next_y     = sum_y + sum_t'(mask_vcount_i);
         next_count = pix_count + 1'b1;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         sum_x       <= '0;
         sum_y       <= '0;
         pix_count   <= '0;
         div_start   <= 1'b0;
         com_valid_o <= 1'b0;
      end else begin
         div_start   <= 1'b0;
         com_valid_o <= 1'b0;
         if (frame_end) begin
            // next frame starts from zero while the division runs
            sum_x     <= '0;
            sum_y     <= '0;
            pix_count <= '0;
            // empty frame, nothing to divide
            div_start <= (next_count != '0);
         end else begin
            sum_x     <= next_x;
            sum_y     <= next_y;
            pix_count <= next_count;
         end
         if (both_done) begin
            com_valid_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (frame_end) begin
         x_dividend <= next_x;
         y_dividend <= next_y;
         divisor    <= next_count;
      end
      if (both_done) begin
         // averages fit the count widths
         com_x_o <= x_quot[`HCOUNT_W-1:0];
         com_y_o <= y_quot[`VCOUNT_W-1:0];
      end
   end

   com_divider x_div (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (x_dividend),
      .divisor_i      (divisor),
      .busy_o         (),
      .done_o         (x_done),
      .quotient_o     (x_quot)
   );

   com_divider y_div (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (y_dividend),
      .divisor_i      (divisor),
      .busy_o         (),
      .done_o         (y_done),
      .quotient_o     (y_quot)
   );

   // a frame can hold at most every pixel once
   a_count_bound : assert property (
      @(posedge clk_camera) disable iff (sys_rst_camera)
      pix_count <= sum_t'(`FRAME_W * `FRAME_H)
   );

endmodule

/* tracking/com_divider.sv */
`timescale 1ns/100ps
`include "tracker_settings.svh"

module com_divider
   import tracker_pkg::*;
(
   input  logic clk_camera,
   input  logic sys_rst_camera,
   input  logic start_i,
   input  sum_t dividend_i,
   input  sum_t divisor_i,
   output logic busy_o,
   output logic done_o,
   output sum_t quotient_o
);

   localparam int CNT_W = $clog2(`DIV_W + 1);

   // partial remainder and the divisor held for the whole run
   sum_t             rem;
   sum_t             div_q;
   logic [CNT_W-1:0] bits_left;

   // remainder shifted left with the next dividend bit
   logic [`DIV_W:0]  shifted;
   logic             fits;

   assign shifted = {rem, quotient_o[`DIV_W-1]};
   assign fits    = shifted >= {1'b0, div_q};

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy_o    <= 1'b0;
         done_o    <= 1'b0;
         bits_left <= '0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            busy_o    <= 1'b1;
            bits_left <= CNT_W'(`DIV_W);
         end else if (busy_o) begin
            bits_left <= bits_left - 1'b1;
            // last quotient bit this cycle
            if (bits_left == CNT_W'(1)) begin
               busy_o <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   // quotient_o doubles as the dividend shift register, msb first
   always_ff @(posedge clk_camera) begin
      if (start_i) begin
         rem        <= '0;
         div_q      <= divisor_i;
         quotient_o <= dividend_i;
      end else if (busy_o) begin
         // restoring step, keep the shifted value when the divisor does not fit
         if (fits) begin
            rem <= shifted[`DIV_W-1:0] - div_q;
         end else begin
            rem <= shifted[`DIV_W-1:0];
         end
         quotient_o <= {quotient_o[`DIV_W-2:0], fits};
      end
   end

   // a second start would corrupt the run in progress
   a_no_start_busy : assert property (
      @(posedge clk_camera) disable iff (sys_rst_camera)
      start_i |-> !busy_o
   );

endmodule
